//--- verilog/dsp_settings.svh
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Memory depths in words
`define DSP_PROG_DEPTH 64
`define DSP_RAM_DEPTH  16

// Host register map, byte offsets
`define DSP_REG_CTRL   12'h100
`define DSP_REG_STATUS 12'h104
`define DSP_REG_ACC    12'h108

`endif

//--- verilog/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    typedef logic signed [15:0] dsp_word_t;
    typedef logic signed [31:0] dsp_acc_t;   // Wraps on overflow

    // T field, bits 15 to 11
    typedef enum logic [4:0] {
        op_goto      = 5'b00000,
        op_short_imm = 5'b00010,
        op_f1        = 5'b00110,
        op_long_imm  = 5'b01010,
        op_store_x   = 5'b01100,
        op_load_y    = 5'b01111,
        op_halt      = 5'b11111
    } dsp_op_e;

    typedef enum logic [1:0] {inc_none, inc_up, inc_down, inc_hold} dsp_inc_e;

    typedef enum logic [1:0] {f1_set, f1_add, f1_sub, f1_clr} dsp_f1_e;

endpackage

`default_nettype wire

//--- verilog/dsp_ifs.sv
`default_nettype none

// Decoder to pointer unit and data RAM
interface ymem_if;
    import dsp_pkg::*;

    logic       short_load;
    logic       ram_we;
    logic       post_load;   // RAM access, then post-modify
    logic [1:0] ptr_sel;
    dsp_inc_e   inc_sel;
    logic [8:0] short_imm;

    modport ctrl (output short_load, ram_we, post_load, ptr_sel, inc_sel, short_imm);
    modport ymem (input short_load, ram_we, post_load, ptr_sel, inc_sel, short_imm);
endinterface

// Decoder to arithmetic unit
interface dau_if;
    import dsp_pkg::*;

    logic      imm_load;
    logic      ram_load;
    logic      f1_en;
    dsp_f1_e   f1_op;
    dsp_word_t long_imm;     // Raw fetched word

    modport ctrl (output imm_load, ram_load, f1_en, f1_op, long_imm);
    modport dau (input imm_load, ram_load, f1_en, f1_op, long_imm);
endinterface

`default_nettype wire

//--- verilog/dsp_ctrl.sv
`default_nettype none

`include "dsp_settings.svh"

module dsp_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               busy,
    input  dsp_pkg::dsp_word_t                 rom_dout,
    output logic                               pc_goto,
    output logic                               pc_hold,
    output logic                               halt,
    output logic                               fault,
    output logic [$clog2(`DSP_PROG_DEPTH)-1:0] ja,
    ymem_if.ctrl                               ymem,
    dau_if.ctrl                                dau
);
    import dsp_pkg::*;

    localparam int PC_W = $clog2(`DSP_PROG_DEPTH);

    dsp_op_e op;
    logic    skip;   // Next fetched word is not an instruction

    assign op           = dsp_op_e'(rom_dout[15:11]);
    assign dau.long_imm = rom_dout;   // Second word of a long immediate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            skip            <= 1'b0;
            pc_goto         <= 1'b0;
            pc_hold         <= 1'b0;
            halt            <= 1'b0;
            fault           <= 1'b0;
            ymem.short_load <= 1'b0;
            ymem.ram_we     <= 1'b0;
            ymem.post_load  <= 1'b0;
            dau.imm_load    <= 1'b0;
            dau.ram_load    <= 1'b0;
            dau.f1_en       <= 1'b0;
        end else begin
            skip            <= 1'b0;
            pc_goto         <= 1'b0;
            pc_hold         <= 1'b0;
            halt            <= 1'b0;
            fault           <= 1'b0;
            ymem.short_load <= 1'b0;
            ymem.ram_we     <= 1'b0;
            ymem.post_load  <= 1'b0;
            dau.imm_load    <= 1'b0;
            dau.ram_load    <= 1'b0;
            dau.f1_en       <= 1'b0;
            // Nothing past a fault, nothing while a start restarts the run
            if (busy && !start && !skip && !fault) begin
                case (op)
                    op_goto: begin
                        pc_goto <= 1'b1;
                        skip    <= 1'b1;
                    end
                    op_short_imm: ymem.short_load <= 1'b1;
                    op_long_imm: begin
                        dau.imm_load <= 1'b1;   // x takes the skipped word
                        skip         <= 1'b1;
                    end
                    op_store_x: begin
                        ymem.ram_we    <= 1'b1;
                        ymem.post_load <= 1'b1;
                        skip           <= 1'b1;
                    end
                    op_load_y: begin
                        dau.ram_load   <= 1'b1;
                        ymem.post_load <= 1'b1;
                        skip           <= 1'b1;
                    end
                    op_f1: dau.f1_en <= 1'b1;
                    op_halt: begin
                        halt    <= 1'b1;
                        pc_hold <= 1'b1;
                        skip    <= 1'b1;
                    end
                    default: begin
                        fault   <= 1'b1;   // Unknown T field
                        pc_hold <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Instruction fields, used only alongside their strobes
    always_ff @(posedge clk) begin
        ja             <= rom_dout[PC_W-1:0];
        ymem.ptr_sel   <= (op == op_short_imm) ? rom_dout[10:9] : rom_dout[3:2];
        ymem.inc_sel   <= dsp_inc_e'(rom_dout[1:0]);
        ymem.short_imm <= rom_dout[8:0];
        dau.f1_op      <= dsp_f1_e'(rom_dout[6:5]);
    end

endmodule

`default_nettype wire

//--- verilog/dsp_xaau.sv
`default_nettype none

`include "dsp_settings.svh"

module dsp_xaau (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               pc_goto,
    input  logic                               pc_hold,
    input  logic                               halt,
    input  logic                               fault,
    input  logic [$clog2(`DSP_PROG_DEPTH)-1:0] ja,
    output logic [$clog2(`DSP_PROG_DEPTH)-1:0] pc,
    output logic                               busy,
    output logic                               halted,
    output logic                               faulted
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= '0;
            busy    <= 1'b0;
            halted  <= 1'b0;
            faulted <= 1'b0;
        end else if (start) begin
            pc      <= '0;   // New run from word 0
            busy    <= 1'b1;
            halted  <= 1'b0;
            faulted <= 1'b0;
        end else if (busy) begin
            if (pc_hold) begin
                busy <= 1'b0;                  // pc stays where it stopped
                if (halt) halted <= 1'b1;
                if (fault) faulted <= 1'b1;    // Sticky until next start
            end else if (pc_goto) begin
                pc <= ja;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_ymem.sv
`default_nettype none

`include "dsp_settings.svh"

module dsp_ymem (
    input  logic               clk,
    input  logic               rst,
    ymem_if.ymem               ctrl,
    input  dsp_pkg::dsp_word_t wdata,
    output dsp_pkg::dsp_word_t rdata
);
    import dsp_pkg::*;

    localparam int            AW   = $clog2(`DSP_RAM_DEPTH);
    localparam logic [AW-1:0] LAST = AW'(`DSP_RAM_DEPTH - 1);

    logic [AW-1:0] ptr [4];   // r0 to r3
    logic [AW-1:0] addr;
    dsp_word_t     ram [`DSP_RAM_DEPTH];

    assign addr = ptr[ctrl.ptr_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) ptr[i] <= '0;
        end else if (ctrl.short_load) begin
            ptr[ctrl.ptr_sel] <= ctrl.short_imm[AW-1:0];
        end else if (ctrl.post_load) begin
            // Post-modify after the access, wrapping at the RAM size
            case (ctrl.inc_sel)
                inc_up:   ptr[ctrl.ptr_sel] <= (addr == LAST) ? '0 : addr + 1'b1;
                inc_down: ptr[ctrl.ptr_sel] <= (addr == '0) ? LAST : addr - 1'b1;
                default:  ptr[ctrl.ptr_sel] <= addr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.post_load) begin
            if (ctrl.ram_we) ram[addr] <= wdata;
            else rdata <= ram[addr];   // Valid the following cycle
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_dau.sv
`default_nettype none

module dsp_dau (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    dau_if.dau                 ctrl,
    input  dsp_pkg::dsp_word_t ram_data,
    output dsp_pkg::dsp_word_t x,
    output dsp_pkg::dsp_acc_t  a0
);
    import dsp_pkg::*;

    dsp_word_t y;
    dsp_acc_t  p;
    logic      y_pend;   // RAM data arrives one cycle after the load strobe

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x      <= '0;
            y      <= '0;
            p      <= '0;
            a0     <= '0;
            y_pend <= 1'b0;
        end else begin
            y_pend <= ctrl.ram_load;
            if (start) begin
                x  <= '0;
                y  <= '0;
                p  <= '0;
                a0 <= '0;
            end else begin
                // p follows x*y from the same edge that changes x or y
                if (ctrl.imm_load) begin
                    x <= ctrl.long_imm;
                    p <= dsp_acc_t'(ctrl.long_imm) * dsp_acc_t'(y);
                end else if (y_pend) begin
                    y <= ram_data;
                    p <= dsp_acc_t'(x) * dsp_acc_t'(ram_data);
                end
                if (ctrl.f1_en) begin
                    case (ctrl.f1_op)
                        f1_set:  a0 <= p;
                        f1_add:  a0 <= a0 + p;
                        f1_sub:  a0 <= a0 - p;
                        default: a0 <= '0;   // f1_clr
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_host_axil.sv
`default_nettype none

`include "dsp_settings.svh"

module dsp_host_axil (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [11:0]                        awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [31:0]                        wdata,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [11:0]                        araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [31:0]                        rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,
    input  logic [$clog2(`DSP_PROG_DEPTH)-1:0] pc,
    output dsp_pkg::dsp_word_t                 rom_dout,
    output logic                               start,
    input  logic                               busy,
    input  logic                               halted,
    input  logic                               fault,
    input  dsp_pkg::dsp_acc_t                  a0
);
    import dsp_pkg::*;

    localparam int          PA       = $clog2(`DSP_PROG_DEPTH);
    localparam logic [11:0] PROG_END = 12'(`DSP_PROG_DEPTH * 4);

    dsp_word_t prog_mem [`DSP_PROG_DEPTH];
    logic      wr_go;
    logic      rd_go;
    logic      aw_prog;
    logic      ar_prog;

    assign wr_go    = awvalid && wvalid && !bvalid;   // Blocked while B is pending
    assign rd_go    = arvalid && !rvalid;
    assign awready  = wr_go;
    assign wready   = wr_go;
    assign arready  = rd_go;
    assign aw_prog  = awaddr < PROG_END;
    assign ar_prog  = araddr < PROG_END;
    assign rresp    = 2'b00;             // Reads always OKAY
    assign rom_dout = prog_mem[pc];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= 2'b00;
            start  <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            start <= wr_go && (awaddr == `DSP_REG_CTRL) && wdata[0];
            if (wr_go) begin
                bvalid <= 1'b1;
                bresp  <= (aw_prog && busy) ? 2'b10 : 2'b00;   // SLVERR on a busy core
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go && aw_prog && !busy) prog_mem[awaddr[PA+1:2]] <= dsp_word_t'(wdata[15:0]);
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            if (ar_prog) begin
                rdata <= {16'd0, prog_mem[araddr[PA+1:2]]};
            end else begin
                case (araddr)
                    `DSP_REG_STATUS: rdata <= {29'd0, fault, halted, busy};
                    `DSP_REG_ACC:    rdata <= a0;
                    default:         rdata <= '0;   // CTRL reads back zero
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_top.sv
`default_nettype none

`include "dsp_settings.svh"

module dsp_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import dsp_pkg::*;

    localparam int PC_W = $clog2(`DSP_PROG_DEPTH);

    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] ja;
    dsp_word_t       rom_dout;
    dsp_word_t       ram_rdata;
    dsp_word_t       x;
    dsp_acc_t        a0;
    logic            start;
    logic            busy;
    logic            halted;
    logic            faulted;
    logic            pc_goto;
    logic            pc_hold;
    logic            halt;
    logic            fault;   // One-cycle decode strobe

    ymem_if ymem_bus ();
    dau_if  dau_bus ();

    dsp_host_axil host_i (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .pc, .rom_dout, .start, .busy, .halted, .fault(faulted), .a0
    );

    dsp_ctrl ctrl_i (
        .clk, .rst, .start, .busy, .rom_dout,
        .pc_goto, .pc_hold, .halt, .fault, .ja,
        .ymem(ymem_bus), .dau(dau_bus)
    );

    dsp_xaau xaau_i (
        .clk, .rst, .start, .pc_goto, .pc_hold, .halt, .fault, .ja,
        .pc, .busy, .halted, .faulted
    );

    dsp_ymem ymem_i (.clk, .rst, .ctrl(ymem_bus), .wdata(x), .rdata(ram_rdata));

    dsp_dau dau_i (.clk, .rst, .start, .ctrl(dau_bus), .ram_data(ram_rdata), .x, .a0);

endmodule

`default_nettype wire

//--- test/tb_dsp_top.sv
`default_nettype none

`include "dsp_settings.svh"

module tb_dsp_top;
    import dsp_pkg::*;

    logic        clk;
    logic        rst;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    dsp_word_t prog_q[$];
    dsp_word_t dot_q[$];
    dsp_word_t prog_img [`DSP_PROG_DEPTH];
    dsp_word_t ref_ram [`DSP_RAM_DEPTH];   // Model of the data RAM
    int        ref_ptr [4];
    int        errors = 0;
    int        tests = 0;
    int        err_mark;
    int        aw_cnt = 0;   // Rising edges with awready high
    int        w_cnt = 0;
    int        ar_cnt = 0;
    integer    seed = 1460;
    logic [1:0]  resp;
    logic [31:0] data;
    dsp_acc_t    exp_acc;
    logic        exp_halt;
    logic        exp_fault;

    dsp_top dsp_top_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Ready strobes counted where the slave samples them
    always @(posedge clk) begin
        if (awready) aw_cnt <= aw_cnt + 1;
        if (wready) w_cnt <= w_cnt + 1;
        if (arready) ar_cnt <= ar_cnt + 1;
    end

    function automatic dsp_word_t enc(dsp_op_e op, logic [10:0] f);
        return {op, f};
    endfunction

    function automatic void bump_pointer(int n, logic [1:0] m);
        if (m == 2'd1) ref_ptr[n] = (ref_ptr[n] + 1) % `DSP_RAM_DEPTH;
        if (m == 2'd2) ref_ptr[n] = (ref_ptr[n] + `DSP_RAM_DEPTH - 1) % `DSP_RAM_DEPTH;
    endfunction

    // Instruction-level model of the core
    function automatic dsp_acc_t ref_run(output logic halted, output logic faulted);
        int        pc;
        dsp_word_t w;
        dsp_word_t x;
        dsp_word_t y;
        dsp_acc_t  p;
        dsp_acc_t  a;
        pc = 0;
        x = '0;
        y = '0;
        p = '0;
        a = '0;
        halted = 1'b0;
        faulted = 1'b0;
        for (int steps = 0; steps < 500; steps++) begin
            w = prog_img[pc];
            case (w[15:11])
                op_goto: pc = int'(w[5:0]);
                op_short_imm: begin
                    ref_ptr[w[10:9]] = int'(w[8:0]) % `DSP_RAM_DEPTH;
                    pc++;
                end
                op_long_imm: begin
                    x = prog_img[pc + 1];   // Second word is the value
                    p = x * y;
                    pc += 2;
                end
                op_store_x: begin
                    ref_ram[ref_ptr[w[3:2]]] = x;
                    bump_pointer(w[3:2], w[1:0]);
                    pc += 2;
                end
                op_load_y: begin
                    y = ref_ram[ref_ptr[w[3:2]]];
                    p = x * y;
                    bump_pointer(w[3:2], w[1:0]);
                    pc += 2;
                end
                op_f1: begin
                    case (w[6:5])
                        2'd0:    a = p;
                        2'd1:    a = a + p;
                        2'd2:    a = a - p;
                        default: a = '0;
                    endcase
                    pc++;
                end
                op_halt: begin
                    halted = 1'b1;
                    return a;
                end
                default: begin
                    faulted = 1'b1;
                    return a;
                end
            endcase
        end
        return a;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] val,
                             input int delay, output logic [1:0] br);
        int n;
        int aw0;
        int w0;
        @(negedge clk);
        aw0     = aw_cnt;
        w0      = w_cnt;
        awaddr  = addr;
        wdata   = val;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (delay == 0);
        for (n = 0; n < 50 && !bvalid; n++) @(negedge clk);
        assert (bvalid) else begin
            $display("Write to 0x%03h was never answered", addr);
            errors++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        br      = bresp;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            assert (bvalid) else begin
                $display("Write response dropped before bready at %0t", $time);
                errors++;
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_val("awready cycles", 32'(aw_cnt - aw0), 32'd1);   // Only the accept cycle
        check_val("wready cycles", 32'(w_cnt - w0), 32'd1);
    endtask

    task automatic axi_read(input logic [11:0] addr, input int delay,
                            output logic [31:0] rd, output logic [1:0] rr);
        int n;
        int ar0;
        @(negedge clk);
        ar0     = ar_cnt;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (delay == 0);
        for (n = 0; n < 50 && !rvalid; n++) @(negedge clk);
        assert (rvalid) else begin
            $display("Read of 0x%03h was never answered", addr);
            errors++;
        end
        arvalid = 1'b0;
        rd      = rdata;
        rr      = rresp;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            assert (rvalid) else begin
                $display("Read data dropped before rready at %0t", $time);
                errors++;
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_val("arready cycles", 32'(ar_cnt - ar0), 32'd1);
    endtask

    task automatic load_program();
        logic [1:0] br;
        foreach (prog_q[i]) begin
            prog_img[i] = prog_q[i];
            axi_write(12'(4 * i), {16'd0, prog_q[i]}, 0, br);
            check_val("bresp", 32'(br), 32'd0);
        end
    endtask

    task automatic run_program();
        logic [1:0]  br;
        logic [31:0] st;
        logic [1:0]  rr;
        int          n;
        axi_write(`DSP_REG_CTRL, 32'd1, 0, br);
        for (n = 0; n < 200; n++) begin
            axi_read(`DSP_REG_STATUS, 0, st, rr);
            if (!st[0]) break;
        end
        assert (n < 200) else begin
            $display("Core still busy after %0d status polls", n);
            errors++;
        end
    endtask

    task automatic emit_mem(dsp_op_e op, logic [1:0] ptr, logic [1:0] inc);
        prog_q.push_back(enc(op, {7'd0, ptr, inc}));
        prog_q.push_back(16'h0000);   // Skipped slot
    endtask

    task automatic emit_long(dsp_word_t v);
        prog_q.push_back(enc(op_long_imm, 11'd0));
        prog_q.push_back(v);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "passed" : "failed");
    endtask

    task automatic check_run(string name);
        exp_acc = ref_run(exp_halt, exp_fault);
        run_program();
        axi_read(`DSP_REG_ACC, 0, data, resp);
        check_val("acc", data, exp_acc);
        axi_read(`DSP_REG_STATUS, 0, data, resp);
        check_val("status", data, {29'd0, exp_fault, exp_halt, 1'b0});
        end_test(name);
    endtask

    initial begin
        #(100 * 100000);
        $display("Simulation time limit reached");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        err_mark = errors;
        axi_read(`DSP_REG_STATUS, 0, data, resp);
        check_val("status", data, 32'd0);
        check_val("rresp", 32'(resp), 32'd0);
        axi_read(`DSP_REG_ACC, 0, data, resp);
        check_val("acc", data, 32'd0);
        check_val("rresp", 32'(resp), 32'd0);
        end_test("reset state");

        // Store eight values through r0, reload them as y through r1
        err_mark = errors;
        prog_q.delete();
        prog_q.push_back(enc(op_short_imm, {2'd0, 9'd0}));
        prog_q.push_back(enc(op_short_imm, {2'd1, 9'd0}));
        for (int i = 0; i < 8; i++) begin
            emit_long(dsp_word_t'($random(seed)));
            emit_mem(op_store_x, 2'd0, 2'd1);
        end
        for (int i = 0; i < 8; i++) begin
            if (i % 4 == 0) emit_long(dsp_word_t'($random(seed)));
            emit_mem(op_load_y, 2'd1, 2'd1);
            prog_q.push_back(enc(op_f1, {4'd0, (i == 0) ? 2'd0 : 2'd1, 5'd0}));
        end
        prog_q.push_back(enc(op_halt, 11'd0));
        dot_q = prog_q;
        load_program();
        check_run("dot product");

        // Decrement past zero, increment past the top
        err_mark = errors;
        prog_q.delete();
        prog_q.push_back(enc(op_short_imm, {2'd2, 9'd1}));
        for (int i = 0; i < 3; i++) begin
            emit_long(dsp_word_t'($random(seed)));
            emit_mem(op_store_x, 2'd2, 2'd2);
        end
        prog_q.push_back(enc(op_short_imm, {2'd3, 9'd15}));
        emit_mem(op_load_y, 2'd3, 2'd1);
        prog_q.push_back(enc(op_f1, {4'd0, 2'd0, 5'd0}));
        emit_mem(op_load_y, 2'd3, 2'd1);
        prog_q.push_back(enc(op_f1, {4'd0, 2'd2, 5'd0}));
        prog_q.push_back(enc(op_f1, {4'd0, 2'd3, 5'd0}));
        emit_mem(op_load_y, 2'd3, 2'd0);
        prog_q.push_back(enc(op_f1, {4'd0, 2'd2, 5'd0}));
        prog_q.push_back(enc(op_halt, 11'd0));
        load_program();
        check_run("post-modify wrap");

        err_mark = errors;
        prog_q.delete();
        prog_q.push_back(enc(op_short_imm, {2'd0, 9'd5}));
        emit_long(dsp_word_t'($random(seed)));
        prog_q.push_back(enc(op_goto, 11'd6));
        prog_q.push_back(16'h0800);   // Unknown opcodes that the goto skips
        prog_q.push_back(16'h0800);
        emit_mem(op_store_x, 2'd0, 2'd0);
        emit_mem(op_load_y, 2'd0, 2'd0);
        prog_q.push_back(enc(op_f1, {4'd0, 2'd0, 5'd0}));
        prog_q.push_back(enc(op_halt, 11'd0));
        load_program();
        check_run("goto");

        err_mark = errors;
        prog_q.delete();
        emit_long(16'sd7);
        prog_q.push_back(16'h0800);
        prog_q.push_back(enc(op_halt, 11'd0));
        load_program();
        check_run("unknown opcode");

        // Program write during a run, with slow response ready
        err_mark = errors;
        prog_q = dot_q;
        load_program();
        exp_acc = ref_run(exp_halt, exp_fault);
        axi_write(`DSP_REG_CTRL, 32'd1, 0, resp);
        axi_write(12'h000, {16'd0, enc(op_halt, 11'd0)}, 3, resp);
        check_val("bresp", 32'(resp), 32'd2);
        run_program();
        axi_read(`DSP_REG_ACC, 3, data, resp);
        check_val("acc", data, exp_acc);
        axi_read(12'h000, 0, data, resp);
        check_val("prog[0]", data, {16'd0, dot_q[0]});
        run_program();
        axi_read(`DSP_REG_ACC, 0, data, resp);
        check_val("acc", data, exp_acc);
        end_test("write while busy");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/dsp_pkg.sv
verilog/dsp_ifs.sv
verilog/dsp_ctrl.sv
verilog/dsp_xaau.sv
verilog/dsp_ymem.sv
verilog/dsp_dau.sv
verilog/dsp_host_axil.sv
verilog/dsp_top.sv
test/tb_dsp_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dsp_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
